//--- source/tile_pkg.sv
// Tile shared definitions
package tile_pkg;

  localparam int unsigned AddrWidth  = 32;
  localparam int unsigned DataWidth  = 32;
  localparam int unsigned BeWidth    = 4;
  localparam int unsigned ByteOffset = 2;
  localparam int unsigned NumBanks   = 4;
  localparam int unsigned BankSel    = 2;
  localparam int unsigned NumTiles   = 4;
  localparam int unsigned TileSel    = 2;
  localparam int unsigned RowWidth   = 6;

  // Shared region is 4 KiB, fields are byte, bank, tile, row from the LSB up
  localparam logic [AddrWidth-1:0] TcdmBase = 32'h1000_0000;
  localparam int unsigned RegionMsb = 12;

  typedef logic [TileSel-1:0] tile_id_t;

  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    logic                 we;
    logic [DataWidth-1:0] wdata;
    logic [BeWidth-1:0]   be;
  } core_req_t;

  typedef struct packed {
    logic [DataWidth-1:0] data;
  } core_resp_t;

  typedef struct packed {
    logic [RowWidth-1:0]  row;
    logic                 we;
    logic [DataWidth-1:0] wdata;
    logic [BeWidth-1:0]   be;
  } bank_req_t;

  // Same layout as a core request once it leaves the tile
  typedef core_req_t remote_req_t;

  typedef struct packed {
    logic [DataWidth-1:0] data;
  } remote_resp_t;

endpackage

//--- source/fall_through_reg.sv
// One-entry fall-through register
`timescale 1ns/1ps

module fall_through_reg #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic rst_i,
  input  T     data_i,
  input  logic valid_i,
  output logic ready_o,
  output T     data_o,
  output logic valid_o,
  input  logic ready_i
);

  logic live_q;
  logic full_q;
  logic store;
  T     data_q;

  // Quiet until reset is released
  assign ready_o = live_q && !full_q;
  assign valid_o = full_q || (live_q && valid_i);
  assign data_o  = full_q ? data_q : data_i;

  // Accepted but not taken downstream this cycle
  assign store = valid_i && ready_o && !ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      live_q <= 1'b0;
      full_q <= 1'b0;
    end else begin
      live_q <= 1'b1;
      if (full_q && ready_i) begin
        full_q <= 1'b0;
      end else if (store) begin
        full_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (store) begin
      data_q <= data_i;
    end
  end

endmodule

//--- source/tile_addr_decoder.sv
// Per-port address decoder
`timescale 1ns/1ps

module tile_addr_decoder
  import tile_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_i,
  input  tile_id_t           tile_id_i,
  input  core_req_t          req_i,
  input  logic               req_valid_i,
  output logic               req_ready_o,
  output bank_req_t          local_req_o,
  output logic [BankSel-1:0] local_bank_o,
  output logic               local_valid_o,
  input  logic               local_grant_i,
  output remote_req_t        remote_req_o,
  output logic               remote_valid_o,
  input  logic               remote_ready_i,
  input  logic               resp_done_i
);

  localparam int unsigned BankLsb = ByteOffset;
  localparam int unsigned TileLsb = ByteOffset + BankSel;
  localparam int unsigned RowLsb  = TileLsb + TileSel;

  logic       en_q;
  logic [1:0] cnt_q;
  logic       cur_remote_q;
  logic       in_region;
  logic       is_local;
  logic       blocked;
  logic       accept;

  assign in_region = req_i.addr[AddrWidth-1:RegionMsb] == TcdmBase[AddrWidth-1:RegionMsb];
  assign is_local  = in_region && (req_i.addr[TileLsb +: TileSel] == tile_id_i);

  // Full counter, or a target switch while the other side still owes responses
  assign blocked = (cnt_q == 2'd3) || ((cnt_q != 2'd0) && (cur_remote_q == is_local));

  assign local_valid_o  = en_q && req_valid_i && is_local && !blocked;
  assign remote_valid_o = en_q && req_valid_i && !is_local && !blocked;
  assign req_ready_o    = en_q && !blocked && (is_local ? local_grant_i : remote_ready_i);
  assign accept         = req_valid_i && req_ready_o;

  assign local_req_o.row   = req_i.addr[RowLsb +: RowWidth];
  assign local_req_o.we    = req_i.we;
  assign local_req_o.wdata = req_i.wdata;
  assign local_req_o.be    = req_i.be;
  assign local_bank_o      = req_i.addr[BankLsb +: BankSel];

  // Swap tile and bank fields so the upper network routes on the tile
  always_comb begin
    remote_req_o = req_i;
    if (in_region) begin
      remote_req_o.addr = {req_i.addr[AddrWidth-1:RowLsb],
                           req_i.addr[BankLsb +: BankSel],
                           req_i.addr[TileLsb +: TileSel],
                           req_i.addr[ByteOffset-1:0]};
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      en_q         <= 1'b0;
      cnt_q        <= 2'd0;
      cur_remote_q <= 1'b0;
    end else begin
      en_q  <= 1'b1;
      cnt_q <= cnt_q + {1'b0, accept} - {1'b0, resp_done_i};
      if (accept) begin
        cur_remote_q <= !is_local;
      end
    end
  end

  // Every response must match an earlier accepted request
  cnt_no_underflow: assert property (
    @(posedge clk_i) disable iff (rst_i) resp_done_i |-> (cnt_q != 2'd0)
  ) else $error("response without outstanding request");

endmodule

//--- source/bank_arbiter.sv
// Round-robin bank arbiter
`timescale 1ns/1ps

module bank_arbiter
  import tile_pkg::*;
#(
  parameter int unsigned NumPorts = 2,
  parameter int unsigned PortW    = (NumPorts > 1) ? $clog2(NumPorts) : 1
) (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic      [NumPorts-1:0]          valid_i,
  input  logic      [NumPorts-1:0][BankSel-1:0] bank_i,
  input  bank_req_t [NumPorts-1:0]          req_i,
  output logic      [NumPorts-1:0]          grant_o,
  output bank_req_t [NumBanks-1:0]          bank_req_o,
  output logic      [NumBanks-1:0]          bank_valid_o,
  output logic      [NumBanks-1:0][PortW-1:0] bank_port_o
);

  logic [NumBanks-1:0][PortW-1:0]    rr_q;
  logic [NumPorts-1:0][NumBanks-1:0] gnt;

  // Search from each bank's pointer for the first requesting port
  always_comb begin
    logic [PortW-1:0] idx;
    idx = '0;
    for (int b = 0; b < NumBanks; b++) begin
      bank_valid_o[b] = 1'b0;
      bank_port_o[b]  = '0;
      for (int i = 0; i < NumPorts; i++) begin
        idx = rr_q[b] + PortW'(i);
        if (!bank_valid_o[b] && valid_i[idx] && (bank_i[idx] == BankSel'(b))) begin
          bank_valid_o[b] = 1'b1;
          bank_port_o[b]  = idx;
        end
      end
      bank_req_o[b] = req_i[bank_port_o[b]];
    end
  end

  for (genvar p = 0; p < NumPorts; p++) begin : gen_grant
    for (genvar b = 0; b < NumBanks; b++) begin : gen_bank
      assign gnt[p][b] = bank_valid_o[b] && (bank_port_o[b] == PortW'(p));
    end
    assign grant_o[p] = |gnt[p];

    // A waiting port is served before the same rival wins its bank again
    rr_no_repeat_loss: assert property (
      @(posedge clk_i) disable iff (rst_i)
      (valid_i[p] && !grant_o[p]) |=>
        !(valid_i[p] && !grant_o[p] && (bank_i[p] == $past(bank_i[p])) &&
          (bank_port_o[bank_i[p]] == $past(bank_port_o[bank_i[p]])))
    ) else $error("same port won a bank twice while another port waited");
  end

  // Pointer moves one past the winner
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rr_q <= '0;
    end else begin
      for (int b = 0; b < NumBanks; b++) begin
        if (bank_valid_o[b]) begin
          rr_q[b] <= bank_port_o[b] + PortW'(1);
        end
      end
    end
  end

endmodule

//--- source/tcdm_bank.sv
// Byte-enabled SRAM bank
`timescale 1ns/1ps

module tcdm_bank
  import tile_pkg::*;
#(
  parameter int unsigned NumPorts = 2,
  parameter int unsigned PortW    = (NumPorts > 1) ? $clog2(NumPorts) : 1
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  bank_req_t            req_i,
  input  logic                 valid_i,
  input  logic [PortW-1:0]     port_i,
  output logic                 resp_valid_o,
  output logic [DataWidth-1:0] resp_data_o,
  output logic [PortW-1:0]     resp_port_o
);

  logic [DataWidth-1:0] mem_q [2**RowWidth];

  always_ff @(posedge clk_i) begin
    if (valid_i && req_i.we) begin
      for (int i = 0; i < BeWidth; i++) begin
        if (req_i.be[i]) begin
          mem_q[req_i.row][8*i +: 8] <= req_i.wdata[8*i +: 8];
        end
      end
    end
  end

  // Response one cycle later, writes answer with zero
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      resp_data_o <= req_i.we ? '0 : mem_q[req_i.row];
      resp_port_o <= port_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      resp_valid_o <= 1'b0;
    end else begin
      resp_valid_o <= valid_i;
    end
  end

endmodule

//--- source/resp_router.sv
// Response steering to the ports
`timescale 1ns/1ps

module resp_router
  import tile_pkg::*;
#(
  parameter int unsigned NumPorts = 2,
  parameter int unsigned PortW    = (NumPorts > 1) ? $clog2(NumPorts) : 1
) (
  input  logic         [NumBanks-1:0]                bank_valid_i,
  input  logic         [NumBanks-1:0][DataWidth-1:0] bank_data_i,
  input  logic         [NumBanks-1:0][PortW-1:0]     bank_port_i,
  input  remote_resp_t [NumPorts-1:0]                remote_resp_i,
  input  logic         [NumPorts-1:0]                remote_valid_i,
  output logic         [NumPorts-1:0]                remote_ready_o,
  output core_resp_t   [NumPorts-1:0]                resp_o,
  output logic         [NumPorts-1:0]                resp_valid_o
);

  logic [NumPorts-1:0] local_hit;

  // Cores never stall a response
  assign remote_ready_o = '1;

  always_comb begin
    local_hit = '0;
    for (int p = 0; p < NumPorts; p++) begin
      resp_valid_o[p] = remote_valid_i[p];
      resp_o[p].data  = remote_resp_i[p].data;
    end
    for (int b = 0; b < NumBanks; b++) begin
      if (bank_valid_i[b]) begin
        local_hit[bank_port_i[b]]    = 1'b1;
        resp_valid_o[bank_port_i[b]] = 1'b1;
        resp_o[bank_port_i[b]].data  = bank_data_i[b];
      end
    end
  end

  // The decoder's order guard keeps both sources apart on one port
  always_comb begin
    assert ((local_hit & remote_valid_i) == '0)
      else $error("local and remote response collide on a port");
  end

endmodule

//--- source/tcdm_tile.sv
// TCDM tile top level
`timescale 1ns/1ps

module tcdm_tile
  import tile_pkg::*;
#(
  parameter int unsigned NumPorts = 2
) (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  tile_id_t                     tile_id_i,
  input  core_req_t    [NumPorts-1:0]  core_req_i,
  input  logic         [NumPorts-1:0]  core_req_valid_i,
  output logic         [NumPorts-1:0]  core_req_ready_o,
  output core_resp_t   [NumPorts-1:0]  core_resp_o,
  output logic         [NumPorts-1:0]  core_resp_valid_o,
  output remote_req_t  [NumPorts-1:0]  remote_req_o,
  output logic         [NumPorts-1:0]  remote_req_valid_o,
  input  logic         [NumPorts-1:0]  remote_req_ready_i,
  input  remote_resp_t [NumPorts-1:0]  remote_resp_i,
  input  logic         [NumPorts-1:0]  remote_resp_valid_i,
  output logic         [NumPorts-1:0]  remote_resp_ready_o
);

  localparam int unsigned PortW = (NumPorts > 1) ? $clog2(NumPorts) : 1;

  bank_req_t    [NumPorts-1:0]               local_req;
  logic         [NumPorts-1:0][BankSel-1:0]  local_bank;
  logic         [NumPorts-1:0]               local_valid;
  logic         [NumPorts-1:0]               local_grant;
  remote_req_t  [NumPorts-1:0]               dec_remote_req;
  logic         [NumPorts-1:0]               dec_remote_valid;
  logic         [NumPorts-1:0]               dec_remote_ready;
  remote_resp_t [NumPorts-1:0]               rsp_remote;
  logic         [NumPorts-1:0]               rsp_remote_valid;
  logic         [NumPorts-1:0]               rsp_remote_ready;
  bank_req_t    [NumBanks-1:0]               bank_req;
  logic         [NumBanks-1:0]               bank_valid;
  logic         [NumBanks-1:0][PortW-1:0]    bank_port;
  logic         [NumBanks-1:0]               bank_resp_valid;
  logic         [NumBanks-1:0][DataWidth-1:0] bank_resp_data;
  logic         [NumBanks-1:0][PortW-1:0]    bank_resp_port;

  for (genvar p = 0; p < NumPorts; p++) begin : gen_port
    tile_addr_decoder i_decoder (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .tile_id_i      (tile_id_i),
      .req_i          (core_req_i[p]),
      .req_valid_i    (core_req_valid_i[p]),
      .req_ready_o    (core_req_ready_o[p]),
      .local_req_o    (local_req[p]),
      .local_bank_o   (local_bank[p]),
      .local_valid_o  (local_valid[p]),
      .local_grant_i  (local_grant[p]),
      .remote_req_o   (dec_remote_req[p]),
      .remote_valid_o (dec_remote_valid[p]),
      .remote_ready_i (dec_remote_ready[p]),
      // Each response the core sees retires one outstanding request
      .resp_done_i    (core_resp_valid_o[p])
    );

    fall_through_reg #(
      .T (remote_req_t)
    ) i_remote_req_reg (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .data_i  (dec_remote_req[p]),
      .valid_i (dec_remote_valid[p]),
      .ready_o (dec_remote_ready[p]),
      .data_o  (remote_req_o[p]),
      .valid_o (remote_req_valid_o[p]),
      .ready_i (remote_req_ready_i[p])
    );

    fall_through_reg #(
      .T (remote_resp_t)
    ) i_remote_resp_reg (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .data_i  (remote_resp_i[p]),
      .valid_i (remote_resp_valid_i[p]),
      .ready_o (remote_resp_ready_o[p]),
      .data_o  (rsp_remote[p]),
      .valid_o (rsp_remote_valid[p]),
      .ready_i (rsp_remote_ready[p])
    );
  end

  bank_arbiter #(
    .NumPorts (NumPorts)
  ) i_arbiter (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .valid_i      (local_valid),
    .bank_i       (local_bank),
    .req_i        (local_req),
    .grant_o      (local_grant),
    .bank_req_o   (bank_req),
    .bank_valid_o (bank_valid),
    .bank_port_o  (bank_port)
  );

  for (genvar b = 0; b < NumBanks; b++) begin : gen_bank
    tcdm_bank #(
      .NumPorts (NumPorts)
    ) i_bank (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .req_i        (bank_req[b]),
      .valid_i      (bank_valid[b]),
      .port_i       (bank_port[b]),
      .resp_valid_o (bank_resp_valid[b]),
      .resp_data_o  (bank_resp_data[b]),
      .resp_port_o  (bank_resp_port[b])
    );
  end

  resp_router #(
    .NumPorts (NumPorts)
  ) i_router (
    .bank_valid_i   (bank_resp_valid),
    .bank_data_i    (bank_resp_data),
    .bank_port_i    (bank_resp_port),
    .remote_resp_i  (rsp_remote),
    .remote_valid_i (rsp_remote_valid),
    .remote_ready_o (rsp_remote_ready),
    .resp_o         (core_resp_o),
    .resp_valid_o   (core_resp_valid_o)
  );

endmodule

//--- bench/tile_checker.sv
// TCDM tile response checker
`timescale 1ns/1ps

module tile_checker
  import tile_pkg::*;
#(
  parameter int       NumPorts = 2,
  parameter tile_id_t TileId   = 2'd2
) (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  core_req_t    [NumPorts-1:0]  core_req_i,
  input  logic         [NumPorts-1:0]  core_req_valid_i,
  input  logic         [NumPorts-1:0]  core_req_ready_i,
  input  core_resp_t   [NumPorts-1:0]  core_resp_i,
  input  logic         [NumPorts-1:0]  core_resp_valid_i,
  input  remote_req_t  [NumPorts-1:0]  remote_req_i,
  input  logic         [NumPorts-1:0]  remote_req_valid_i,
  input  logic         [NumPorts-1:0]  remote_req_ready_i,
  input  logic         [NumPorts-1:0]  remote_resp_ready_i,
  output int                           checks_o,
  output int                           errors_o,
  output int                           accepted_o,
  output int                           responded_o
);

  typedef struct packed {
    logic [DataWidth-1:0] data;
    logic [DataWidth-1:0] mask;
    logic                 is_local;
    int                   due;
  } expect_t;

  expect_t              resp_q [NumPorts][$];
  remote_req_t          fwd_q  [NumPorts][$];
  // Reference memory indexed by row and bank, with a per-byte written flag
  logic [DataWidth-1:0] mem    [256];
  logic [BeWidth-1:0]   known  [256];
  int                   cycle;
  int                   rst_edges;

  function automatic logic [DataWidth-1:0] byte_mask(logic [BeWidth-1:0] be);
    logic [DataWidth-1:0] mask;
    for (int i = 0; i < BeWidth; i++) begin
      mask[8*i +: 8] = {8{be[i]}};
    end
    return mask;
  endfunction

  function automatic logic in_region(logic [AddrWidth-1:0] addr);
    return addr[AddrWidth-1:RegionMsb] == TcdmBase[AddrWidth-1:RegionMsb];
  endfunction

  // Tile field (bits 5:4) and bank field (bits 3:2) trade places
  function automatic remote_req_t route_remote(core_req_t req);
    remote_req_t fwd;
    fwd = req;
    if (in_region(req.addr)) begin
      fwd.addr[5:2] = {req.addr[3:2], req.addr[5:4]};
    end
    return fwd;
  endfunction

  task automatic check_low(input string name, input logic [NumPorts-1:0] value);
    checks_o++;
    if (value !== '0) begin
      errors_o++;
      $display("CHECK FAILED %s during reset: got %h expected %h", name, value,
               {NumPorts{1'b0}});
    end
  endtask

  always @(posedge clk_i) begin
    expect_t     exp;
    remote_req_t fwd;
    logic [7:0]  idx;
    if (rst_i) begin
      // Outputs hold X until the first edge
      if (rst_edges > 0) begin
        check_low("core_req_ready_o", core_req_ready_i);
        check_low("core_resp_valid_o", core_resp_valid_i);
        check_low("remote_req_valid_o", remote_req_valid_i);
        check_low("remote_resp_ready_o", remote_resp_ready_i);
      end
      rst_edges++;
      cycle = 0;
      for (int i = 0; i < 256; i++) begin
        known[i] = '0;
      end
    end else begin
      cycle++;
      for (int p = 0; p < NumPorts; p++) begin
        // Responses first, they belong to requests from earlier cycles
        if (core_resp_valid_i[p]) begin
          responded_o++;
          if (resp_q[p].size() == 0) begin
            errors_o++;
            $display("Port %0d returned a response with no request outstanding", p);
          end else begin
            exp = resp_q[p].pop_front();
            checks_o++;
            if ((core_resp_i[p].data & exp.mask) !== (exp.data & exp.mask)) begin
              errors_o++;
              $display("CHECK FAILED core_resp_o[%0d]: got %h expected %h", p,
                       core_resp_i[p].data & exp.mask, exp.data & exp.mask);
            end
            if (exp.is_local && cycle != exp.due) begin
              errors_o++;
              $display("Port %0d local response came in cycle %0d instead of cycle %0d",
                       p, cycle, exp.due);
            end
          end
        end

        if (core_req_valid_i[p] && core_req_ready_i[p]) begin
          accepted_o++;
          exp.due = cycle + 1;
          if (in_region(core_req_i[p].addr) && core_req_i[p].addr[5:4] == TileId) begin
            idx          = {core_req_i[p].addr[11:6], core_req_i[p].addr[3:2]};
            exp.is_local = 1'b1;
            exp.data     = core_req_i[p].we ? '0 : mem[idx];
            exp.mask     = core_req_i[p].we ? '1 : byte_mask(known[idx]);
            if (core_req_i[p].we) begin
              for (int i = 0; i < BeWidth; i++) begin
                if (core_req_i[p].be[i]) begin
                  mem[idx][8*i +: 8] = core_req_i[p].wdata[8*i +: 8];
                  known[idx][i]      = 1'b1;
                end
              end
            end
          end else begin
            fwd          = route_remote(core_req_i[p]);
            exp.is_local = 1'b0;
            exp.data     = core_req_i[p].we ? '0 : fwd.addr ^ 32'hA5A5_A5A5;
            exp.mask     = '1;
            fwd_q[p].push_back(fwd);
          end
          resp_q[p].push_back(exp);
        end

        // A remote request may leave in the cycle the core issues it
        if (remote_req_valid_i[p] && remote_req_ready_i[p]) begin
          if (fwd_q[p].size() == 0) begin
            errors_o++;
            $display("Port %0d sent a remote request that no core issued", p);
          end else begin
            fwd = fwd_q[p].pop_front();
            checks_o++;
            if (remote_req_i[p] !== fwd) begin
              errors_o++;
              $display("CHECK FAILED remote_req_o[%0d]: got %h expected %h", p,
                       remote_req_i[p], fwd);
            end
          end
        end
      end
    end
  end

endmodule

//--- bench/tb_tcdm_tile.sv
// TCDM tile testbench
`timescale 1ns/1ps

module tb_tcdm_tile
  import tile_pkg::*;
();

  localparam int       NumPorts    = 2;
  localparam tile_id_t TileId      = 2'd2;
  localparam int       NumTests    = 3;
  localparam int       NumReqs     = 150;
  localparam int       ResetCycles = 16;
  // Generous per-request bound covering remote round trips and order stalls
  localparam int       CyclesPerReq = 40;
  localparam int       LimitCycles  = ResetCycles + NumTests * NumReqs * CyclesPerReq;

  logic                         clk = 1'b0;
  logic                         rst = 1'b1;
  core_req_t    [NumPorts-1:0]  core_req = '0;
  logic         [NumPorts-1:0]  core_req_valid = '0;
  logic         [NumPorts-1:0]  core_req_ready;
  core_resp_t   [NumPorts-1:0]  core_resp;
  logic         [NumPorts-1:0]  core_resp_valid;
  remote_req_t  [NumPorts-1:0]  remote_req;
  logic         [NumPorts-1:0]  remote_req_valid;
  logic         [NumPorts-1:0]  remote_req_ready = '0;
  remote_resp_t [NumPorts-1:0]  remote_resp = '0;
  logic         [NumPorts-1:0]  remote_resp_valid = '0;
  logic         [NumPorts-1:0]  remote_resp_ready;

  int                   checks;
  int                   errors;
  int                   accepted;
  int                   responded;
  int                   mode = 0;
  int                   quota = 0;
  int                   sent [NumPorts] = '{default: 0};
  int                   last_due [NumPorts] = '{default: 0};
  int                   cycle = 0;
  logic [DataWidth-1:0] reply_q [NumPorts][$];
  int                   due_q [NumPorts][$];
  string                test_names [NumTests] = '{"local_read_write", "same_bank",
                                                  "mixed_targets"};

  tcdm_tile #(
    .NumPorts (NumPorts)
  ) UUT (
    .clk_i               (clk),
    .rst_i               (rst),
    .tile_id_i           (TileId),
    .core_req_i          (core_req),
    .core_req_valid_i    (core_req_valid),
    .core_req_ready_o    (core_req_ready),
    .core_resp_o         (core_resp),
    .core_resp_valid_o   (core_resp_valid),
    .remote_req_o        (remote_req),
    .remote_req_valid_o  (remote_req_valid),
    .remote_req_ready_i  (remote_req_ready),
    .remote_resp_i       (remote_resp),
    .remote_resp_valid_i (remote_resp_valid),
    .remote_resp_ready_o (remote_resp_ready)
  );

  tile_checker #(
    .NumPorts (NumPorts),
    .TileId   (TileId)
  ) i_checker (
    .clk_i               (clk),
    .rst_i               (rst),
    .core_req_i          (core_req),
    .core_req_valid_i    (core_req_valid),
    .core_req_ready_i    (core_req_ready),
    .core_resp_i         (core_resp),
    .core_resp_valid_i   (core_resp_valid),
    .remote_req_i        (remote_req),
    .remote_req_valid_i  (remote_req_valid),
    .remote_req_ready_i  (remote_req_ready),
    .remote_resp_ready_i (remote_resp_ready),
    .checks_o            (checks),
    .errors_o            (errors),
    .accepted_o          (accepted),
    .responded_o         (responded)
  );

  initial begin
    forever #5 clk = ~clk;
  end

  // Mode 0 all local, mode 1 local on bank 1 only, mode 2 mixes 60/30/10
  function automatic core_req_t random_req(int req_mode);
    core_req_t  req;
    int         pick;
    logic [1:0] bank;
    tile_id_t   tile;
    pick = int'($urandom_range(99));
    bank = (req_mode == 1) ? 2'd1 : 2'($urandom_range(3));
    tile = TileId;
    if (req_mode == 2 && pick >= 60) begin
      tile = TileId + 2'($urandom_range(1, 3));
    end
    // Few rows so reads often land on earlier writes
    req.addr = TcdmBase | {20'd0, 6'($urandom_range(3)), tile, bank, 2'b00};
    if (req_mode == 2 && pick >= 90) begin
      req.addr = {4'h2, 26'($urandom), 2'b00};
    end
    req.we    = 1'($urandom_range(1));
    req.wdata = $urandom;
    req.be    = req.we ? 4'($urandom_range(1, 15)) : 4'hF;
    return req;
  endfunction

  // Core request streams, payload held until accepted
  always @(posedge clk) begin
    for (int p = 0; p < NumPorts; p++) begin
      if (rst) begin
        core_req_valid[p] <= 1'b0;
      end else begin
        if (core_req_valid[p] && core_req_ready[p]) begin
          sent[p]++;
        end
        if (!core_req_valid[p] || core_req_ready[p]) begin
          if (sent[p] < quota && $urandom_range(3) != 0) begin
            core_req[p]       <= random_req(mode);
            core_req_valid[p] <= 1'b1;
          end else begin
            core_req_valid[p] <= 1'b0;
          end
        end
      end
    end
  end

  // Remote side answers in order after 1 to 6 cycles
  always @(posedge clk) begin
    int due;
    if (rst) begin
      remote_req_ready  <= '0;
      remote_resp_valid <= '0;
    end else begin
      cycle++;
      for (int p = 0; p < NumPorts; p++) begin
        if (remote_req_valid[p] && remote_req_ready[p]) begin
          due = cycle + int'($urandom_range(1, 6));
          if (due <= last_due[p]) begin
            due = last_due[p] + 1;
          end
          last_due[p] = due;
          due_q[p].push_back(due);
          reply_q[p].push_back(remote_req[p].we ? '0 : remote_req[p].addr ^ 32'hA5A5_A5A5);
        end
        remote_req_ready[p] <= ($urandom_range(3) != 0);
        if (!remote_resp_valid[p] || remote_resp_ready[p]) begin
          if (due_q[p].size() > 0 && due_q[p][0] <= cycle) begin
            void'(due_q[p].pop_front());
            remote_resp[p].data  <= reply_q[p].pop_front();
            remote_resp_valid[p] <= 1'b1;
          end else begin
            remote_resp_valid[p] <= 1'b0;
          end
        end
      end
    end
  end

  initial begin
    int err_mark;
    void'($urandom(32'h6a7ac8f4));
    repeat (ResetCycles) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    $display("Test reset_outputs finished with %0d errors", errors);
    err_mark = errors;
    for (int t = 0; t < NumTests; t++) begin
      mode  = t;
      quota = quota + NumReqs;
      // Drained once every request is accepted and answered
      do begin
        @(negedge clk);
      end while (accepted != NumPorts * quota || responded != accepted);
      $display("Test %s finished with %0d errors", test_names[t], errors - err_mark);
      err_mark = errors;
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin
    #(LimitCycles * 10);
    $display("Watchdog expired before all requests were answered");
    $display("Result: FAILED");
    $finish;
  end

endmodule

//--- tcdm_tile.f
source/tile_pkg.sv
source/fall_through_reg.sv
source/tile_addr_decoder.sv
source/bank_arbiter.sv
source/tcdm_bank.sv
source/resp_router.sv
source/tcdm_tile.sv
bench/tile_checker.sv
bench/tb_tcdm_tile.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the TCDM tile simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_tcdm_tile -f tcdm_tile.f -o sim_tcdm_tile

output="$(./obj_dir/sim_tcdm_tile)"
echo "$output"

if echo "$output" | grep -qx "Result: PASSED"; then
  exit 0
fi
exit 1
